/* slink_ctrl_regs.f */
hdl/slink_apb_pkg.sv
hdl/slink_regs_pkg.sv
hdl/slink_apb_slave.sv
hdl/slink_int_status.sv
hdl/slink_reg_file.sv
hdl/slink_ctrl_regs_top.sv
tests/slink_apb_checker.sv
tests/tb_slink_ctrl_regs.sv

/* Makefile */
# Verilator flow for the link control register block

VERILATOR ?= verilator
TOP       ?= tb_slink_ctrl_regs
FILELIST  ?= slink_ctrl_regs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/slink_ctrl_regs_testdata.mem */
// columns: test id, op (0 write, 1 read, 2 event, 3 pop read, F end), offset,
// data (write data, event bits, aux_status on read, rx packet on pop), expected, pslverr
01_1_00_00000000_00000001_0
01_1_04_00000000_00000000_0
01_1_08_00000000_00000000_0
01_1_0C_00000000_0000001F_0
01_1_14_00000000_00000005_0
01_1_18_00000000_00000026_0
01_1_1C_00000000_00000404_0
02_0_04_FFFFFFFF_00000000_0
02_1_04_00000000_00000001_0
02_0_0C_FFFFFFA5_00000000_0
02_1_0C_00000000_00000025_0
02_0_14_0000FFFA_00000000_0
02_1_14_00000000_0000000A_0
02_0_18_DEADBEEF_00000000_0
02_1_18_00000000_000002EF_0
02_0_1C_12345678_00000000_0
02_1_1C_00000000_00005678_0
03_2_00_00000004_00000004_0
03_1_08_00000000_00000004_0
03_0_08_00000000_00000000_0
03_1_08_00000000_00000004_0
03_0_08_00000004_00000000_0
03_1_08_00000000_00000000_0
03_2_00_00000041_00000041_0
03_0_08_00000001_00000000_0
03_1_08_00000000_00000040_0
04_0_20_A5C3E7F1_00C3E7F1_0
04_1_20_00000010_40000000_0
05_3_24_00ABCDEF_00ABCDEF_0
05_1_28_00000006_00000003_0
05_1_1C_00000001_00015678_0
06_0_30_FFFFFFFF_00000000_1
06_1_30_00000000_00000000_1
06_1_04_00000000_00000001_0
06_1_18_00000000_000002EF_0
00_F_00_00000000_00000000_0

/* tests/tb_slink_ctrl_regs.sv */
// Link control register testbench
`timescale 1ns/1ps
`default_nettype none

module tb_slink_ctrl_regs;
  import slink_apb_pkg::*;
  import slink_regs_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int NUM_RAND  = 8;
  localparam logic [3:0] OP_WRITE = 4'h0;
  localparam logic [3:0] OP_READ  = 4'h1;
  localparam logic [3:0] OP_EVENT = 4'h2;
  localparam logic [3:0] OP_POP   = 4'h3;
  localparam logic [3:0] OP_END   = 4'hF;
  // writable registers for the random pass and their masks
  localparam logic [7:0]  RAND_OFFS [6] = '{SWRESET, ENABLE, INT_ENABLE, ERROR_CONTROL,
                                            COUNT_VAL_1US, AUX_CTRL_STATUS};
  localparam logic [31:0] RAND_MASKS [6] = '{MASK_SWRESET, MASK_ENABLE, MASK_INT,
                                             MASK_ERROR_CONTROL, MASK_COUNT_VAL_1US,
                                             MASK_AUX_CTRL};

  // config expected out of reset, from the register map
  localparam ctrl_cfg_t EXP_CFG_RESET = '{
    swreset:                    1'b1,
    enable:                     1'b0,
    int_en:                     7'b001_1111,
    allow_ecc_corrected:        1'b1,
    ecc_corrected_causes_reset: 1'b0,
    ecc_corrupted_causes_reset: 1'b1,
    crc_corrupted_causes_reset: 1'b0,
    count_val_1us:              10'h026,
    short_pkt_min:              8'd4,
    short_pkt_max:              8'd4
  };

  // one line of the data file
  typedef struct packed {
    logic [7:0]  id;
    logic [3:0]  op;
    logic [7:0]  offset;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic [3:0]  exp_err;
  } vec_t;

  logic        RegClk;
  logic        RegReset;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  int_vec_t    int_events;
  int_vec_t    int_status;
  ctrl_cfg_t   cfg;
  aux_status_t aux_status;
  aux_pkt_t    aux_rx_pkt;
  aux_pkt_t    aux_tx_pkt;
  logic        aux_tx_push;
  logic        aux_rx_pop;

  logic [87:0] vectors [MAX_LINES];
  ctrl_cfg_t   cfg_model;
  int          num_lines;
  int          cycles;
  int          cycle_limit;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  integer      seed;

  slink_ctrl_regs_top u_dut (
    .RegClk      (RegClk),
    .RegReset    (RegReset),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .int_events  (int_events),
    .int_status  (int_status),
    .cfg         (cfg),
    .aux_status  (aux_status),
    .aux_rx_pkt  (aux_rx_pkt),
    .aux_tx_pkt  (aux_tx_pkt),
    .aux_tx_push (aux_tx_push),
    .aux_rx_pop  (aux_rx_pop)
  );

  // 8 ns clock
  initial RegClk = 1'b0;
  always #4 RegClk = ~RegClk;

  // run limit
  always @(posedge RegClk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_rdata(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cfg(input string what, input ctrl_cfg_t got, input ctrl_cfg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_int(input string what, input int_vec_t got, input int_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_strobe(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // expected config after a write with fields at their register bit positions
  function automatic ctrl_cfg_t apply_write(input ctrl_cfg_t cur, input logic [7:0] offset,
                                            input logic [31:0] d);
    ctrl_cfg_t nxt;
    nxt = cur;
    case (offset)
      SWRESET:       nxt.swreset       = d[0];
      ENABLE:        nxt.enable        = d[0];
      INT_ENABLE:    nxt.int_en        = d[NUM_INT-1:0];
      COUNT_VAL_1US: nxt.count_val_1us = d[9:0];
      ERROR_CONTROL: begin
        nxt.allow_ecc_corrected        = d[0];
        nxt.ecc_corrected_causes_reset = d[1];
        nxt.ecc_corrupted_causes_reset = d[2];
        nxt.crc_corrupted_causes_reset = d[3];
      end
      AUX_CTRL_STATUS: begin
        nxt.short_pkt_min = d[7:0];
        nxt.short_pkt_max = d[15:8];
      end
      default: nxt = cur;
    endcase
    return nxt;
  endfunction

  // --------------------
  // bus driver
  // --------------------
  // setup and access then one idle cycle
  // strobes checked in each cycle
  task automatic apb_xfer(input logic wr, input logic [7:0] offset, input logic [31:0] wdata,
                          input aux_status_t status, input aux_pkt_t rx_pkt,
                          input logic exp_push, input logic exp_pop,
                          output logic [31:0] rdata, output logic slverr,
                          output aux_pkt_t tx_pkt);
    @(negedge RegClk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = offset;
    apb_req.pwdata  = wdata;
    aux_status      = status;
    aux_rx_pkt      = rx_pkt;
    #2;
    check_strobe("aux_tx_push in setup", aux_tx_push, 1'b0);
    check_strobe("aux_rx_pop in setup", aux_rx_pop, 1'b0);
    @(negedge RegClk);
    apb_req.penable = 1'b1;
    #2;
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    tx_pkt = aux_tx_pkt;
    check_strobe("aux_tx_push in access", aux_tx_push, exp_push);
    check_strobe("aux_rx_pop in access", aux_rx_pop, exp_pop);
    @(negedge RegClk);
    apb_req = '0;
    #2;
    check_strobe("aux_tx_push after access", aux_tx_push, 1'b0);
    check_strobe("aux_rx_pop after access", aux_rx_pop, 1'b0);
  endtask

  // one data file line
  task automatic run_line(input vec_t v);
    logic [31:0] rd;
    logic        err;
    aux_pkt_t    pkt;
    aux_status_t st;
    aux_pkt_t    rx;
    logic        is_push;
    logic        is_pop;
    is_push = (v.op == OP_WRITE) && (v.offset == AUX_TX_PKT);
    is_pop  = ((v.op == OP_READ) || (v.op == OP_POP)) && (v.offset == AUX_RX_PKT);
    case (v.op)
      OP_WRITE: begin
        apb_xfer(1'b1, v.offset, v.data, aux_status, aux_rx_pkt, is_push, 1'b0,
                 rd, err, pkt);
        check_strobe($sformatf("pslverr on write of %h", v.offset), err, v.exp_err[0]);
        if (is_push) begin
          check_rdata("aux_tx_pkt", {8'h00, pkt}, v.exp_data);
        end
        cfg_model = apply_write(cfg_model, v.offset, v.data);
        check_cfg("cfg after write", cfg, cfg_model);
      end
      OP_READ, OP_POP: begin
        // read lines carry aux_status and pop lines the rx packet
        st = (v.op == OP_READ) ? v.data[4:0] : aux_status;
        rx = (v.op == OP_POP) ? v.data[23:0] : aux_rx_pkt;
        apb_xfer(1'b0, v.offset, 32'h0, st, rx, 1'b0, is_pop, rd, err, pkt);
        check_rdata($sformatf("read of %h", v.offset), rd, v.exp_data);
        check_strobe($sformatf("pslverr on read of %h", v.offset), err, v.exp_err[0]);
        check_cfg("cfg after read", cfg, cfg_model);
      end
      OP_EVENT: begin
        // hold events for 4 cycles
        // status sets 3 edges after the rise
        @(negedge RegClk);
        int_events = v.data[NUM_INT-1:0];
        repeat (4) @(negedge RegClk);
        int_events = '0;
        repeat (2) @(negedge RegClk);
        #2;
        check_int("int_status port", int_status, v.exp_data[NUM_INT-1:0]);
      end
      default: begin
        errors++;
        $display("unknown operation %h in a data line of test %0d", v.op, v.id);
      end
    endcase
  endtask

  task automatic report_test(input int id, input int n);
    tests_run++;
    if (n == 0) begin
      $display("test %0d finished without errors", id);
    end else begin
      tests_failed++;
      $display("test %0d finished with %0d errors", id, n);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    vec_t        v;
    int          cur_id;
    int          test_errors;
    int          idx;
    logic [31:0] wd;
    logic [31:0] rd;
    logic        err;
    aux_pkt_t    pkt;
    apb_req      = '0;
    int_events   = '0;
    aux_status   = '0;
    aux_rx_pkt   = '0;
    RegReset     = 1'b1;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    cycle_limit  = 200;
    seed         = 40227;
    cfg_model    = EXP_CFG_RESET;

    $readmemh("tests/slink_ctrl_regs_testdata.mem", vectors);
    num_lines = 0;
    for (int i = 0; i < MAX_LINES; i++) begin
      v = vectors[i];
      if ($isunknown(vectors[i]) || (v.op == OP_END)) begin
        break;
      end
      num_lines++;
    end
    cycle_limit = 4 * num_lines + 200;
    if (num_lines == 0) begin
      errors++;
      $display("the data file holds no test lines");
    end

    repeat (8) @(posedge RegClk);
    @(negedge RegClk);
    RegReset = 1'b0;
    #2;
    check_cfg("cfg after reset", cfg, cfg_model);
    check_strobe("pslverr after reset", apb_rsp.pslverr, 1'b0);
    check_strobe("aux_tx_push after reset", aux_tx_push, 1'b0);
    check_strobe("aux_rx_pop after reset", aux_rx_pop, 1'b0);
    check_int("int_status after reset", int_status, '0);

    // data file tests with one report per id
    cur_id      = -1;
    test_errors = errors;
    for (int i = 0; i < num_lines; i++) begin
      v = vectors[i];
      if (int'(v.id) != cur_id) begin
        if (cur_id >= 0) begin
          report_test(cur_id, errors - test_errors);
        end
        cur_id      = int'(v.id);
        test_errors = errors;
      end
      run_line(v);
    end
    if (cur_id >= 0) begin
      report_test(cur_id, errors - test_errors);
    end

    // random writes read back as data under the field mask
    test_errors = errors;
    for (int n = 0; n < NUM_RAND; n++) begin
      idx = $unsigned($random(seed)) % 6;
      wd  = $random(seed);
      apb_xfer(1'b1, RAND_OFFS[idx], wd, '0, aux_rx_pkt, 1'b0, 1'b0, rd, err, pkt);
      cfg_model = apply_write(cfg_model, RAND_OFFS[idx], wd);
      check_cfg("cfg after random write", cfg, cfg_model);
      apb_xfer(1'b0, RAND_OFFS[idx], 32'h0, '0, aux_rx_pkt, 1'b0, 1'b0, rd, err, pkt);
      check_rdata($sformatf("random read of %h", RAND_OFFS[idx]), rd,
                  wd & RAND_MASKS[idx]);
    end
    report_test(cur_id + 1, errors - test_errors);

    if (u_dut.u_apb_slave.u_apb_checker.fail_count != 0) begin
      errors += u_dut.u_apb_slave.u_apb_checker.fail_count;
      $display("APB protocol assertions failed %0d times",
               u_dut.u_apb_slave.u_apb_checker.fail_count);
    end
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/slink_apb_checker.sv */
// APB protocol checks
`timescale 1ns/1ps
`default_nettype none

module slink_apb_checker (
  input logic                    RegClk,
  input logic                    RegReset,
  input slink_apb_pkg::apb_req_t apb_req,
  input slink_apb_pkg::apb_rsp_t apb_rsp
);

  // number of failed assertions so far
  int fail_count = 0;

  // --------------------
  // protocol rules
  // --------------------
  // access cycle only right after a setup cycle
  penable_after_setup: assert property (@(posedge RegClk) disable iff (RegReset)
    (apb_req.psel && apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
  else begin
    $error("penable high without a preceding setup cycle");
    fail_count = fail_count + 1;
  end

  // zero wait states
  pready_high: assert property (@(posedge RegClk) disable iff (RegReset)
    apb_rsp.pready)
  else begin
    $error("pready low");
    fail_count = fail_count + 1;
  end

  // error response only in an access cycle
  pslverr_in_access: assert property (@(posedge RegClk) disable iff (RegReset)
    apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
  else begin
    $error("pslverr high outside an access cycle");
    fail_count = fail_count + 1;
  end

endmodule

bind slink_apb_slave slink_apb_checker u_apb_checker (
  .RegClk   (RegClk),
  .RegReset (RegReset),
  .apb_req  (apb_req),
  .apb_rsp  (apb_rsp)
);

`default_nettype wire

/* hdl/slink_ctrl_regs_top.sv */
// Link control register block
`timescale 1ns/1ps
`default_nettype none

module slink_ctrl_regs_top (
  input  logic                        RegClk,
  input  logic                        RegReset,
  input  slink_apb_pkg::apb_req_t     apb_req,
  output slink_apb_pkg::apb_rsp_t     apb_rsp,
  input  slink_regs_pkg::int_vec_t    int_events,
  output slink_regs_pkg::int_vec_t    int_status,
  output slink_regs_pkg::ctrl_cfg_t   cfg,
  input  slink_regs_pkg::aux_status_t aux_status,
  input  slink_regs_pkg::aux_pkt_t    aux_rx_pkt,
  output slink_regs_pkg::aux_pkt_t    aux_tx_pkt,
  output logic                        aux_tx_push,
  output logic                        aux_rx_pop
);

  // decoded access, slave to both register blocks
  slink_regs_pkg::reg_access_t reg_access;
  // readback back to the slave
  logic [31:0]                 rdata;

  // --------------------
  // bus front end
  // --------------------
  slink_apb_slave u_apb_slave (
    .RegClk     (RegClk),
    .RegReset   (RegReset),
    .apb_req    (apb_req),
    .rdata      (rdata),
    .apb_rsp    (apb_rsp),
    .reg_access (reg_access)
  );

  // sticky interrupts, also read back through the reg file
  slink_int_status u_int_status (
    .RegClk     (RegClk),
    .RegReset   (RegReset),
    .reg_access (reg_access),
    .int_events (int_events),
    .int_status (int_status)
  );

  slink_reg_file u_reg_file (
    .RegClk      (RegClk),
    .RegReset    (RegReset),
    .reg_access  (reg_access),
    .int_status  (int_status),
    .aux_status  (aux_status),
    .aux_rx_pkt  (aux_rx_pkt),
    .cfg         (cfg),
    .aux_tx_pkt  (aux_tx_pkt),
    .aux_tx_push (aux_tx_push),
    .aux_rx_pop  (aux_rx_pop),
    .rdata       (rdata)
  );

endmodule

`default_nettype wire

/* hdl/slink_reg_file.sv */
// Control register file
`timescale 1ns/1ps
`default_nettype none

module slink_reg_file (
  input  logic                                  RegClk,
  input  logic                                  RegReset,
  input  slink_regs_pkg::reg_access_t           reg_access,
  input  slink_regs_pkg::int_vec_t              int_status,
  input  slink_regs_pkg::aux_status_t           aux_status,
  input  slink_regs_pkg::aux_pkt_t              aux_rx_pkt,
  output slink_regs_pkg::ctrl_cfg_t             cfg,
  output slink_regs_pkg::aux_pkt_t              aux_tx_pkt,
  output logic                                  aux_tx_push,
  output logic                                  aux_rx_pop,
  output logic [slink_apb_pkg::APB_DATA_W-1:0]  rdata
);
  import slink_apb_pkg::*;
  import slink_regs_pkg::*;

  ctrl_cfg_t             cfg_q;
  logic [APB_DATA_W-1:0] wr_mask;
  logic [APB_DATA_W-1:0] wr_word;
  err_ctrl_reg_t         err_w;
  aux_ctrl_reg_t         aux_ctrl_w;
  aux_tx_reg_t           aux_tx_w;
  err_ctrl_reg_t         err_r;
  aux_ctrl_reg_t         aux_ctrl_r;
  aux_tx_reg_t           aux_tx_r;
  aux_rx_status_reg_t    aux_rx_stat_r;

  // --------------------
  // write path
  // --------------------
  // keep reserved bits out of the fields
  always_comb begin
    case (reg_access.offset)
      SWRESET:         wr_mask = MASK_SWRESET;
      ENABLE:          wr_mask = MASK_ENABLE;
      INT_ENABLE:      wr_mask = MASK_INT;
      ERROR_CONTROL:   wr_mask = MASK_ERROR_CONTROL;
      COUNT_VAL_1US:   wr_mask = MASK_COUNT_VAL_1US;
      AUX_CTRL_STATUS: wr_mask = MASK_AUX_CTRL;
      AUX_TX_PKT:      wr_mask = MASK_AUX_TX_PKT;
      default:         wr_mask = '0;
    endcase
  end

  assign wr_word    = reg_access.wdata & wr_mask;
  assign err_w      = err_ctrl_reg_t'(wr_word);
  assign aux_ctrl_w = aux_ctrl_reg_t'(wr_word);
  assign aux_tx_w   = aux_tx_reg_t'(wr_word);

  // updates on the edge that ends the access cycle
  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      cfg_q <= CFG_RESET;
    end else if (reg_access.wr) begin
      case (reg_access.offset)
        SWRESET:       cfg_q.swreset       <= wr_word[0];
        ENABLE:        cfg_q.enable        <= wr_word[0];
        INT_ENABLE:    cfg_q.int_en        <= wr_word[NUM_INT-1:0];
        COUNT_VAL_1US: cfg_q.count_val_1us <= wr_word[9:0];
        ERROR_CONTROL: begin
          cfg_q.allow_ecc_corrected        <= err_w.allow_ecc_corrected;
          cfg_q.ecc_corrected_causes_reset <= err_w.ecc_corrected_causes_reset;
          cfg_q.ecc_corrupted_causes_reset <= err_w.ecc_corrupted_causes_reset;
          cfg_q.crc_corrupted_causes_reset <= err_w.crc_corrupted_causes_reset;
        end
        AUX_CTRL_STATUS: begin
          cfg_q.short_pkt_min <= aux_ctrl_w.short_pkt_min;
          cfg_q.short_pkt_max <= aux_ctrl_w.short_pkt_max;
        end
        // int status is handled next door, the rest is read-only
        default:       cfg_q <= cfg_q;
      endcase
    end
  end

  assign cfg = cfg_q;

  // --------------------
  // aux fifo strobes
  // --------------------
  // push even when full, fifo drops it
  assign aux_tx_push = reg_access.wr & (reg_access.offset == AUX_TX_PKT);
  assign aux_tx_pkt  = aux_tx_push ? aux_tx_w.pkt : '0;
  assign aux_rx_pop  = reg_access.rd & (reg_access.offset == AUX_RX_PKT);

  // --------------------
  // readback
  // --------------------
  assign err_r = '{
    rsvd:                       '0,
    crc_corrupted_causes_reset: cfg_q.crc_corrupted_causes_reset,
    ecc_corrupted_causes_reset: cfg_q.ecc_corrupted_causes_reset,
    ecc_corrected_causes_reset: cfg_q.ecc_corrected_causes_reset,
    allow_ecc_corrected:        cfg_q.allow_ecc_corrected
  };

  assign aux_ctrl_r = '{
    rsvd:          '0,
    fifos_active:  aux_status.fifos_active,
    short_pkt_max: cfg_q.short_pkt_max,
    short_pkt_min: cfg_q.short_pkt_min
  };

  // packet field reads back as zero
  assign aux_tx_r = '{
    tx_rempty: aux_status.tx_rempty,
    tx_wfull:  aux_status.tx_wfull,
    rsvd:      '0,
    pkt:       '0
  };

  assign aux_rx_stat_r = '{
    rsvd:      '0,
    rx_rempty: aux_status.rx_rempty,
    rx_wfull:  aux_status.rx_wfull
  };

  // captured offset only
  always_comb begin
    case (reg_access.offset)
      SWRESET:         rdata = APB_DATA_W'(cfg_q.swreset);
      ENABLE:          rdata = APB_DATA_W'(cfg_q.enable);
      INT_STATUS:      rdata = APB_DATA_W'(int_status);
      INT_ENABLE:      rdata = APB_DATA_W'(cfg_q.int_en);
      ERROR_CONTROL:   rdata = err_r;
      COUNT_VAL_1US:   rdata = APB_DATA_W'(cfg_q.count_val_1us);
      AUX_CTRL_STATUS: rdata = aux_ctrl_r;
      AUX_TX_PKT:      rdata = aux_tx_r;
      AUX_RX_PKT:      rdata = APB_DATA_W'(aux_rx_pkt);
      AUX_RX_STATUS:   rdata = aux_rx_stat_r;
      default:         rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/slink_int_status.sv */
// Sticky interrupt status
`timescale 1ns/1ps
`default_nettype none

module slink_int_status (
  input  logic                        RegClk,
  input  logic                        RegReset,
  input  slink_regs_pkg::reg_access_t reg_access,
  input  slink_regs_pkg::int_vec_t    int_events,
  output slink_regs_pkg::int_vec_t    int_status
);
  import slink_regs_pkg::*;

  // two-flop synchronizer
  int_vec_t sync_ff1;
  int_vec_t sync_ff2;
  // one cycle back, for the edge
  int_vec_t edge_ff;
  int_vec_t rise;
  int_vec_t clr;
  int_vec_t status_q;

  // --------------------
  // synchronize events
  // --------------------
  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      sync_ff1 <= '0;
      sync_ff2 <= '0;
      edge_ff  <= '0;
    end else begin
      sync_ff1 <= int_events;
      sync_ff2 <= sync_ff1;
      edge_ff  <= sync_ff2;
    end
  end

  // rising edge, event is the third edge after input rise
  assign rise = sync_ff2 & ~edge_ff;

  // --------------------
  // write one to clear
  // --------------------
  // only bits written as 1 clear
  assign clr = (reg_access.wr && (reg_access.offset == INT_STATUS)) ?
               reg_access.wdata[NUM_INT-1:0] : '0;

  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      status_q <= '0;
    end else begin
      // clear beats a new edge in the same cycle
      status_q <= (status_q | rise) & ~clr;
    end
  end

  assign int_status = status_q;

endmodule

`default_nettype wire

/* hdl/slink_apb_slave.sv */
// APB slave front end
`timescale 1ns/1ps
`default_nettype none

module slink_apb_slave (
  input  logic                        RegClk,
  input  logic                        RegReset,
  input  slink_apb_pkg::apb_req_t     apb_req,
  input  logic [31:0]                 rdata,
  output slink_apb_pkg::apb_rsp_t     apb_rsp,
  output slink_regs_pkg::reg_access_t reg_access
);
  import slink_apb_pkg::*;
  import slink_regs_pkg::*;

  // phase of the last cycle
  apb_phase_e            phase_q;
  apb_phase_e            phase_d;
  logic [APB_ADDR_W-1:0] addr_q;
  logic [APB_DATA_W-1:0] wdata_q;
  logic                  write_q;
  logic                  setup_cyc;
  logic                  access_cyc;
  logic                  mapped;

  // --------------------
  // phase tracking
  // --------------------
  assign setup_cyc  = apb_req.psel & ~apb_req.penable;
  // access only counts right after a setup
  assign access_cyc = apb_req.psel & apb_req.penable & (phase_q == SETUP);

  always_comb begin
    if (setup_cyc) begin
      phase_d = SETUP;
    end else if (access_cyc) begin
      phase_d = ACCESS;
    end else begin
      phase_d = IDLE;
    end
  end

  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      phase_q <= IDLE;
      addr_q  <= '0;
      write_q <= 1'b0;
    end else begin
      phase_q <= phase_d;
      // capture on the setup edge
      if (setup_cyc) begin
        addr_q  <= apb_req.paddr;
        write_q <= apb_req.pwrite;
      end
    end
  end

  always_ff @(posedge RegClk) begin
    if (setup_cyc) begin
      wdata_q <= apb_req.pwdata;
    end
  end

  // --------------------
  // offset decode
  // --------------------
  always_comb begin
    case (addr_q)
      SWRESET, ENABLE, INT_STATUS, INT_ENABLE, ERROR_CONTROL,
      COUNT_VAL_1US, AUX_CTRL_STATUS, AUX_TX_PKT, AUX_RX_PKT,
      AUX_RX_STATUS: mapped = 1'b1;
      default:       mapped = 1'b0;
    endcase
  end

  // strobes only reach mapped registers
  assign reg_access.offset = addr_q;
  assign reg_access.wdata  = wdata_q;
  assign reg_access.wr     = access_cyc & write_q & mapped;
  assign reg_access.rd     = access_cyc & ~write_q & mapped;

  // unmapped reads return zero
  assign apb_rsp.prdata  = mapped ? rdata : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access_cyc & ~mapped;

endmodule

`default_nettype wire

/* hdl/slink_regs_pkg.sv */
// Link control register map
`default_nettype none

package slink_regs_pkg;

  // --------------------
  // register offsets
  // --------------------
  typedef enum logic [7:0] {
    SWRESET         = 8'h00,
    ENABLE          = 8'h04,
    INT_STATUS      = 8'h08,
    INT_ENABLE      = 8'h0C,
    ERROR_CONTROL   = 8'h14,
    COUNT_VAL_1US   = 8'h18,
    AUX_CTRL_STATUS = 8'h1C,
    AUX_TX_PKT      = 8'h20,
    AUX_RX_PKT      = 8'h24,
    AUX_RX_STATUS   = 8'h28
  } reg_addr_e;

  // interrupt sources, one bit each
  localparam int NUM_INT = 7;
  typedef logic [NUM_INT-1:0] int_vec_t;

  localparam int INT_IDX_ECC_CORRUPTED = 0;
  localparam int INT_IDX_ECC_CORRECTED = 1;
  localparam int INT_IDX_CRC_CORRUPTED = 2;
  localparam int INT_IDX_AUX_RX_WFULL  = 3;
  localparam int INT_IDX_RESET_SEEN    = 4;
  localparam int INT_IDX_WAKE_SEEN     = 5;
  localparam int INT_IDX_IN_PSTATE     = 6;

  // one aux short packet
  typedef logic [23:0] aux_pkt_t;

  // decoded access from the apb slave
  typedef struct packed {
    logic [7:0]  offset;
    logic [31:0] wdata;
    logic        wr;
    logic        rd;
  } reg_access_t;

  // configuration outputs
  typedef struct packed {
    logic       swreset;
    logic       enable;
    int_vec_t   int_en;
    logic       allow_ecc_corrected;
    logic       ecc_corrected_causes_reset;
    logic       ecc_corrupted_causes_reset;
    logic       crc_corrupted_causes_reset;
    logic [9:0] count_val_1us;
    logic [7:0] short_pkt_min;
    logic [7:0] short_pkt_max;
  } ctrl_cfg_t;

  // fifo flags from the aux link
  typedef struct packed {
    logic tx_wfull;
    logic tx_rempty;
    logic rx_wfull;
    logic rx_rempty;
    logic fifos_active;
  } aux_status_t;

  // --------------------
  // 32-bit register layouts
  // --------------------
  typedef struct packed {
    logic [27:0] rsvd;
    logic        crc_corrupted_causes_reset;
    logic        ecc_corrupted_causes_reset;
    logic        ecc_corrected_causes_reset;
    logic        allow_ecc_corrected;
  } err_ctrl_reg_t;

  typedef struct packed {
    logic [14:0] rsvd;
    logic        fifos_active;
    logic [7:0]  short_pkt_max;
    logic [7:0]  short_pkt_min;
  } aux_ctrl_reg_t;

  // packet on write, tx flags on read
  typedef struct packed {
    logic     tx_rempty;
    logic     tx_wfull;
    logic [5:0] rsvd;
    aux_pkt_t pkt;
  } aux_tx_reg_t;

  typedef struct packed {
    logic [29:0] rsvd;
    logic        rx_rempty;
    logic        rx_wfull;
  } aux_rx_status_reg_t;

  // writable bits per register
  localparam logic [31:0] MASK_SWRESET       = 32'h0000_0001;
  localparam logic [31:0] MASK_ENABLE        = 32'h0000_0001;
  localparam logic [31:0] MASK_INT           = 32'h0000_007F;
  localparam logic [31:0] MASK_ERROR_CONTROL = 32'h0000_000F;
  localparam logic [31:0] MASK_COUNT_VAL_1US = 32'h0000_03FF;
  localparam logic [31:0] MASK_AUX_CTRL      = 32'h0000_FFFF;
  localparam logic [31:0] MASK_AUX_TX_PKT    = 32'h00FF_FFFF;

  // wake and pstate interrupts start disabled
  localparam int_vec_t INT_EN_RESET = (int_vec_t'(1) << INT_IDX_ECC_CORRUPTED)
                                    | (int_vec_t'(1) << INT_IDX_ECC_CORRECTED)
                                    | (int_vec_t'(1) << INT_IDX_CRC_CORRUPTED)
                                    | (int_vec_t'(1) << INT_IDX_AUX_RX_WFULL)
                                    | (int_vec_t'(1) << INT_IDX_RESET_SEEN);

  localparam ctrl_cfg_t CFG_RESET = '{
    swreset:                    1'b1,
    enable:                     1'b0,
    int_en:                     INT_EN_RESET,
    allow_ecc_corrected:        1'b1,
    ecc_corrected_causes_reset: 1'b0,
    ecc_corrupted_causes_reset: 1'b1,
    crc_corrupted_causes_reset: 1'b0,
    count_val_1us:              10'h026,
    short_pkt_min:              8'd4,
    short_pkt_max:              8'd4
  };

endpackage

`default_nettype wire

/* hdl/slink_apb_pkg.sv */
// APB bus types
`default_nettype none

package slink_apb_pkg;

  // --------------------
  // bus widths
  // --------------------
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // phase of the slave, as seen one cycle back
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_phase_e;

  // --------------------
  // request, master to slave
  // --------------------
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // response, zero wait states so pready is tied
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire
